/* rtl/rx_mon_pkg.sv */
package rx_mon_pkg;

  // ----------------------------------------------------------
  // Scalar widths that carry a meaning
  // ----------------------------------------------------------

  // Buffer occupancy in words, 0 to 3
  typedef logic [1:0] depth_t;

  // Slot index inside the three-entry buffer, 0 to 2
  typedef logic [1:0] ptr_t;

  // One event count; the window length uses the same width so a count never overflows
  typedef logic [15:0] evt_count_t;

  // ----------------------------------------------------------
  // Buffer status word, 7 bits, MSB first
  // ----------------------------------------------------------

  // The event bits and out_ready_q describe the previous cycle
  // The depth field is the current occupancy
  typedef struct packed {
    logic   in_stall;
    logic   in_taken;
    logic   out_stall;
    logic   out_taken;
    logic   out_ready_q;
    depth_t depth;
  } buf_status_t;

  // Monitor results, one count per event bit
  typedef struct packed {
    evt_count_t in_stall_cnt;
    evt_count_t in_taken_cnt;
    evt_count_t out_stall_cnt;
    evt_count_t out_taken_cnt;
  } mon_counts_t;

  // Monitor state machine encoding
  typedef enum logic [1:0] {
    MON_IDLE = 2'd0,
    MON_RUN  = 2'd1,
    MON_DONE = 2'd2
  } mon_state_e;

endpackage

/* rtl/rx_triple_buffer.sv */
`timescale 1ns/1ps

// Three-entry decoupling buffer between two valid/ready ports on one clock
// Words leave in the order they arrived
module rx_triple_buffer
  import rx_mon_pkg::*;
#(
  parameter int DATA_W         = 32,
  parameter int RESET_DATAPATH = 0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  output logic              in_ready,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  input  logic              out_ready,
  output buf_status_t       status
);

  // ----------------------------------------------------------
  // Storage and control registers
  // ----------------------------------------------------------

  // Data slots, written at the write pointer and read at the read pointer
  logic [DATA_W-1:0] slot_q [3];

  ptr_t   wr_ptr_q;
  ptr_t   wr_ptr_d;
  ptr_t   rd_ptr_q;
  ptr_t   rd_ptr_d;
  depth_t depth_q;
  depth_t depth_d;
  logic   in_ready_q;

  // Registered event bits plus the sampled out_ready, in status order
  logic [4:0] evt_q;

  // Handshake decodes for the current cycle
  logic in_taken;
  logic in_stall;
  logic out_taken;
  logic out_stall;

  // ----------------------------------------------------------
  // Port handshakes
  // ----------------------------------------------------------

  assign in_ready  = in_ready_q;
  assign in_taken  = in_valid & in_ready_q;
  assign in_stall  = in_valid & ~in_ready_q;

  // Output is valid whenever a word is held, so a word written at an edge shows from that edge
  assign out_valid = (depth_q != depth_t'(0));
  assign out_taken = out_valid & out_ready;
  assign out_stall = out_valid & ~out_ready;

  // Head of the buffer is always presented, and holds while the read pointer holds
  assign out_data  = slot_q[rd_ptr_q];

  // ----------------------------------------------------------
  // Next-state logic
  // ----------------------------------------------------------

  always_comb begin
    // Depth moves only on a lone accept or a lone send
    case ({in_taken, out_taken})
      2'b10:   depth_d = depth_q + depth_t'(1);
      2'b01:   depth_d = depth_q - depth_t'(1);
      default: depth_d = depth_q;
    endcase

    // Pointers step through slots 0, 1, 2 and wrap back to 0
    wr_ptr_d = wr_ptr_q;
    if (in_taken) begin
      wr_ptr_d = (wr_ptr_q == ptr_t'(2)) ? ptr_t'(0) : wr_ptr_q + ptr_t'(1);
    end

    rd_ptr_d = rd_ptr_q;
    if (out_taken) begin
      rd_ptr_d = (rd_ptr_q == ptr_t'(2)) ? ptr_t'(0) : rd_ptr_q + ptr_t'(1);
    end
  end

  // ----------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      depth_q    <= '0;
      // Empty after reset, so upstream may send at once
      in_ready_q <= 1'b1;
      evt_q      <= '0;
    end else begin
      wr_ptr_q   <= wr_ptr_d;
      rd_ptr_q   <= rd_ptr_d;
      depth_q    <= depth_d;
      // Drops in the same cycle the third slot fills, rises the cycle after one frees
      in_ready_q <= (depth_d != depth_t'(3));
      evt_q      <= {in_stall, in_taken, out_stall, out_taken, out_ready};
    end
  end

  // Event bits lag the ports by one cycle, depth is current
  assign status = {evt_q, depth_q};

  // ----------------------------------------------------------
  // Data slots
  // ----------------------------------------------------------

  if (RESET_DATAPATH != 0) begin : g_slot_rst
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        slot_q <= '{default: '0};
      end else if (in_taken) begin
        slot_q[wr_ptr_q] <= in_data;
      end
    end
  end else begin : g_slot_norst
    always_ff @(posedge clk) begin
      if (in_taken) begin
        slot_q[wr_ptr_q] <= in_data;
      end
    end
  end

endmodule

/* rtl/rx_event_counters.sv */
`timescale 1ns/1ps

// Four event counters fed by the buffer status event bits
// Each counter is as wide as the window, so it cannot wrap within one window
module rx_event_counters
  import rx_mon_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        count_clear,
  input  logic        count_en,
  input  buf_status_t events,
  output mon_counts_t counts
);

  // ----------------------------------------------------------
  // Increment values
  // ----------------------------------------------------------

  // Each event bit widened to a count, zero when counting is off
  evt_count_t inc_in_stall;
  evt_count_t inc_in_taken;
  evt_count_t inc_out_stall;
  evt_count_t inc_out_taken;

  mon_counts_t counts_q;

  always_comb begin
    inc_in_stall  = '0;
    inc_in_taken  = '0;
    inc_out_stall = '0;
    inc_out_taken = '0;
    if (count_en) begin
      inc_in_stall  = evt_count_t'(events.in_stall);
      inc_in_taken  = evt_count_t'(events.in_taken);
      inc_out_stall = evt_count_t'(events.out_stall);
      inc_out_taken = evt_count_t'(events.out_taken);
    end
  end

  // ----------------------------------------------------------
  // Count registers
  // ----------------------------------------------------------

  // Clear wins over counting, although the FSM never raises both at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counts_q <= '0;
    end else if (count_clear) begin
      counts_q <= '0;
    end else begin
      counts_q.in_stall_cnt  <= counts_q.in_stall_cnt + inc_in_stall;
      counts_q.in_taken_cnt  <= counts_q.in_taken_cnt + inc_in_taken;
      counts_q.out_stall_cnt <= counts_q.out_stall_cnt + inc_out_stall;
      counts_q.out_taken_cnt <= counts_q.out_taken_cnt + inc_out_taken;
    end
  end

  // Counts hold between windows until the next clear
  assign counts = counts_q;

endmodule

/* rtl/rx_mon_fsm.sv */
`timescale 1ns/1ps

// Monitor state machine with a window down-timer
// A start in IDLE or DONE clears the counters and opens a window of mon_window cycles
module rx_mon_fsm
  import rx_mon_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       mon_start,
  input  evt_count_t mon_window,
  output logic       count_clear,
  output logic       count_en,
  output logic       mon_done
);

  // ----------------------------------------------------------
  // State and timer
  // ----------------------------------------------------------

  mon_state_e state_q;
  mon_state_e state_d;
  evt_count_t timer_q;
  evt_count_t timer_d;

  // Start is only honoured outside a running window
  logic start_ok;

  assign start_ok = mon_start && (state_q != MON_RUN);

  always_comb begin
    state_d = state_q;
    timer_d = timer_q;
    case (state_q)
      MON_IDLE, MON_DONE: begin
        if (start_ok) begin
          // Window length is sampled together with the start strobe
          state_d = MON_RUN;
          timer_d = mon_window;
        end
      end
      MON_RUN: begin
        // Timer holds the cycles left in the window, including this one
        timer_d = timer_q - evt_count_t'(1);
        if (timer_q == evt_count_t'(1)) begin
          state_d = MON_DONE;
        end
      end
      default: begin
        state_d = MON_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MON_IDLE;
      timer_q <= '0;
    end else begin
      state_q <= state_d;
      timer_q <= timer_d;
    end
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------

  // Clear lands on the same edge that enters RUN
  assign count_clear = start_ok;

  // Status bits lag the ports by one cycle, so RUN covers the start cycle onward
  assign count_en    = (state_q == MON_RUN);
  assign mon_done    = (state_q == MON_DONE);

endmodule

/* rtl/rx_buffer_top.sv */
`timescale 1ns/1ps

// Receive buffer with its event monitor
// The buffer status feeds both the output port and the counters
module rx_buffer_top
  import rx_mon_pkg::*;
#(
  parameter int DATA_W         = 32,
  parameter int RESET_DATAPATH = 0
) (
  input  logic              clk,
  input  logic              rst_n,
  // Upstream port
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  output logic              in_ready,
  // Downstream port
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  input  logic              out_ready,
  // Monitor control and results
  input  logic              mon_start,
  input  evt_count_t        mon_window,
  output logic              mon_done,
  output mon_counts_t       mon_counts,
  output buf_status_t       buf_status
);

  // ----------------------------------------------------------
  // Monitor control between FSM and counters
  // ----------------------------------------------------------

  logic count_clear;
  logic count_en;

  rx_triple_buffer #(
    .DATA_W         (DATA_W),
    .RESET_DATAPATH (RESET_DATAPATH)
  ) rx_triple_buffer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .status    (buf_status)
  );

  rx_mon_fsm rx_mon_fsm_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .mon_start   (mon_start),
    .mon_window  (mon_window),
    .count_clear (count_clear),
    .count_en    (count_en),
    .mon_done    (mon_done)
  );

  // Counters read the event bits of the same status word seen at the port
  rx_event_counters rx_event_counters_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .count_clear (count_clear),
    .count_en    (count_en),
    .events      (buf_status),
    .counts      (mon_counts)
  );

endmodule

/* testbench/tb_rx_buffer_top.sv */
`timescale 1ns/1ps

// Table-driven testbench for the receive buffer and its event monitor
// A reference queue tracks the buffer contents and a tally tracks the port events
module tb_rx_buffer_top
  import rx_mon_pkg::*;
();

  localparam int NUM_ROWS = 6;

  // One stimulus row, with the probabilities in sixteenths
  // A ready probability of 0 holds out_ready low until the window has closed
  typedef struct packed {
    logic [4:0]  vld_p;
    logic [4:0]  rdy_p;
    logic [15:0] words;
    logic [15:0] window;
    logic        restart;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  logic        out_valid;
  logic        out_ready;
  logic        mon_start;
  logic        mon_done;
  logic [31:0] in_data;
  logic [31:0] out_data;
  evt_count_t  mon_window;
  mon_counts_t mon_counts;
  buf_status_t buf_status;

  row_t        rows [NUM_ROWS];
  string       row_names [NUM_ROWS];
  string       cnt_names [4];
  logic [31:0] lfsr = 32'h8ede;
  logic [31:0] model_q [$];
  mon_counts_t tally;
  // Status event bits and out_ready expected after the next edge, in status order
  logic [4:0]  exp_evt = '0;
  int          cycle_cnt = 0;
  int          cycle_limit = 200;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  always #50 clk = ~clk;

  rx_buffer_top #(.DATA_W(32)) rx_buffer_top_inst (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
    .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
    .mon_start(mon_start), .mon_window(mon_window), .mon_done(mon_done),
    .mon_counts(mon_counts), .buf_status(buf_status)
  );

  // ----------------------------------------------------------
  // Random bits, checks and the run limit
  // ----------------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // True with a probability of p sixteenths
  function automatic logic coin(input logic [4:0] p);
    return rand_bits(4) < p;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h at %0t", sig, exp, act, $time);
    errors++;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped after %0d cycles because a test never finished", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // One table row, one cycle per loop pass at 5 ns past the edge
  // ----------------------------------------------------------

  task automatic run_row(input int idx);
    row_t        r;
    int          rel, sent, recv, err0, mid;
    logic        in_hold, tk_in, tk_out;
    logic [31:0] word;
    r = rows[idx];
    rel = 0;
    sent = 0;
    recv = 0;
    in_hold = 1'b0;
    err0 = errors;
    tally = '0;
    // The extra strobe lands inside the running window
    mid = 1 + (r.window - 1) / 2;
    while (rel <= r.window + 1 || recv < r.words) begin
      // A pending word keeps its valid and data until it is taken
      if (!in_hold) begin
        in_valid = (sent < r.words) && coin(r.vld_p);
        if (in_valid)
          in_data = rand_bits(32);
      end
      out_ready  = (r.rdy_p == 0) ? (rel > r.window) : coin(r.rdy_p);
      mon_start  = (rel == 0) || (r.restart && rel == mid);
      mon_window = (rel == 0) ? r.window : r.window + 16'd7;
      // Occupancy after the previous edge
      if (out_valid !== (model_q.size() != 0))
        report_mismatch("out_valid", model_q.size() != 0, out_valid);
      if (in_ready !== (model_q.size() != 3))
        report_mismatch("in_ready", model_q.size() != 3, in_ready);
      if (buf_status.depth !== depth_t'(model_q.size()))
        report_mismatch("buf_status.depth", model_q.size(), buf_status.depth);
      // Event bits and the sampled out_ready describe the cycle before the last edge
      if (buf_status[6:2] !== exp_evt)
        report_mismatch("buf_status events", exp_evt, buf_status[6:2]);
      // Window is open for cycles 1 to L and closes at the edge that ends cycle L
      if (rel >= 1 && rel <= r.window && mon_done !== 1'b0)
        report_mismatch("mon_done", 0, mon_done);
      if (rel == 1 && mon_counts !== '0)
        report_mismatch("mon_counts", 0, mon_counts);
      // Done and the final counts hold from that edge until the next start
      if (rel > r.window) begin
        if (mon_done !== 1'b1)
          report_mismatch("mon_done", 1, mon_done);
        for (int k = 0; k < 4; k++) begin
          if (mon_counts[k*16 +: 16] !== tally[k*16 +: 16])
            report_mismatch(cnt_names[k], tally[k*16 +: 16], mon_counts[k*16 +: 16]);
        end
      end
      // An input transfer follows the handshake seen at the port
      // The output side is judged from the model alone
      tk_out = (model_q.size() != 0) && out_ready;
      tk_in  = in_valid && in_ready;
      exp_evt = {in_valid && !tk_in, tk_in, (model_q.size() != 0) && !out_ready, tk_out,
                 out_ready};
      if (rel < r.window) begin
        tally.in_stall_cnt  = tally.in_stall_cnt + evt_count_t'(exp_evt[4]);
        tally.in_taken_cnt  = tally.in_taken_cnt + evt_count_t'(exp_evt[3]);
        tally.out_stall_cnt = tally.out_stall_cnt + evt_count_t'(exp_evt[2]);
        tally.out_taken_cnt = tally.out_taken_cnt + evt_count_t'(exp_evt[1]);
      end
      if (tk_out) begin
        word = model_q.pop_front();
        recv++;
        if (out_data !== word)
          report_mismatch("out_data", word, out_data);
      end
      if (tk_in) begin
        model_q.push_back(in_data);
        sent++;
      end
      if (model_q.size() > 3) begin
        $display("Reference queue holds %0d words, more than the buffer has", model_q.size());
        errors++;
      end
      in_hold = in_valid && !tk_in;
      rel++;
      @(posedge clk);
      #5;
    end
    if (errors == err0) begin
      tests_passed++;
      $display("Test %s ok, %0d words, window %0d", row_names[idx], r.words, r.window);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", row_names[idx], errors - err0);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus table and the main sequence
  // ----------------------------------------------------------

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    mon_start = 1'b0;
    mon_window = '0;
    cnt_names = '{"out_taken_cnt", "out_stall_cnt", "in_taken_cnt", "in_stall_cnt"};
    // Columns are valid odds, ready odds, words, window and the mid-window start
    rows[0] = {5'd16, 5'd16, 16'd48, 16'd40, 1'b0};
    rows[1] = {5'd10, 5'd10, 16'd60, 16'd50, 1'b1};
    rows[2] = {5'd14, 5'd6, 16'd40, 16'd60, 1'b0};
    rows[3] = {5'd16, 5'd0, 16'd24, 16'd20, 1'b1};
    rows[4] = {5'd6, 5'd14, 16'd30, 16'd25, 1'b0};
    rows[5] = {5'd12, 5'd12, 16'd20, 16'd1, 1'b1};
    row_names = '{"full_rate", "random_mix", "slow_sink", "ready_low", "slow_source",
                  "short_window"};
    for (int i = 0; i < NUM_ROWS; i++)
      cycle_limit = cycle_limit + rows[i].words * 16 + rows[i].window;
    repeat (8) @(posedge clk);
    #5;
    rst_n = 1'b1;
    // Reset values, before any stimulus
    if (in_ready !== 1'b1)
      report_mismatch("in_ready", 1, in_ready);
    if (out_valid !== 1'b0 || mon_done !== 1'b0)
      report_mismatch("out_valid/mon_done", 0, {out_valid, mon_done});
    if (buf_status !== '0)
      report_mismatch("buf_status", 0, buf_status);
    if (mon_counts !== '0)
      report_mismatch("mon_counts", 0, mon_counts);
    if (errors == 0) begin
      tests_passed++;
      $display("Test reset_values ok");
    end else begin
      tests_failed++;
      $display("Test reset_values failed with %0d errors", errors);
    end
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* flist.f */
rtl/rx_mon_pkg.sv
rtl/rx_triple_buffer.sv
rtl/rx_event_counters.sv
rtl/rx_mon_fsm.sv
rtl/rx_buffer_top.sv
testbench/tb_rx_buffer_top.sv
